// File: verilog.f
logic/usb_pkg.sv
logic/axis_pkg.sv
logic/packet_decoder.sv
logic/packet_encoder.sv
logic/packet_fifo.sv
logic/bulk_endpoint_ctrl.sv
logic/usb_bulk_core.sv
dv/tb_usb_bulk_core.sv

// File: Bender.yml
package:
  name: usb_bulk_core

sources:
  - logic/usb_pkg.sv
  - logic/axis_pkg.sv
  - logic/packet_decoder.sv
  - logic/packet_encoder.sv
  - logic/packet_fifo.sv
  - logic/bulk_endpoint_ctrl.sv
  - logic/usb_bulk_core.sv
  - target: simulation
    files:
      - dv/tb_usb_bulk_core.sv

// File: dv/tb_usb_bulk_core.sv
`timescale 1ns/10ps

module tb_usb_bulk_core;

  import usb_pkg::*;
  import axis_pkg::*;

  localparam logic [6:0] DEV_ADDR = 7'd5;
  localparam logic [3:0] OUT_EP   = 4'd1;
  localparam logic [3:0] IN_EP    = 4'd2;
  localparam int         MAX_PKT  = 8;
  localparam int         DEPTH    = 32;
  // Upper bound on the bytes of all packets in the run in both directions
  localparam int PACKET_BYTES = 400;
  localparam int CYCLE_LIMIT  = 2 * PACKET_BYTES + 2000;

  logic       clock;
  logic       areset_n;
  logic       rx_valid_i;
  byte_beat_t rx_beat_i;
  logic       tx_valid_o;
  logic       tx_ready_i;
  byte_beat_t tx_beat_o;
  logic       s_axis_valid_i;
  logic       s_axis_ready_o;
  byte_beat_t s_axis_beat_i;
  logic       m_axis_valid_o;
  logic       m_axis_ready_i;
  byte_beat_t m_axis_beat_o;
  logic       usb_sof_o;
  logic       usb_crc_error_o;

  logic [31:0] lfsr = 32'hf59b;
  logic        hold_m;
  logic        s_fire;
  int          cycles;
  int          sof_count;
  int          crc_count;
  logic [7:0]  wire_q[$];
  logic [7:0]  pay_q[$];
  logic [7:0]  in_src[$];
  byte_beat_t  user_q[$];
  byte_beat_t  tx_q[$];
  byte_beat_t  m_q[$];
  byte_beat_t  exp_m[$];

  usb_bulk_core #(
    .DEVICE_ADDRESS(DEV_ADDR),
    .OUT_ENDPOINT(OUT_EP),
    .IN_ENDPOINT(IN_EP),
    .MAX_PACKET(MAX_PKT),
    .FIFO_DEPTH(DEPTH)
  ) dut_i (
    .clock(clock),
    .areset_n(areset_n),
    .rx_valid_i(rx_valid_i),
    .rx_beat_i(rx_beat_i),
    .tx_valid_o(tx_valid_o),
    .tx_ready_i(tx_ready_i),
    .tx_beat_o(tx_beat_o),
    .s_axis_valid_i(s_axis_valid_i),
    .s_axis_ready_o(s_axis_ready_o),
    .s_axis_beat_i(s_axis_beat_i),
    .m_axis_valid_o(m_axis_valid_o),
    .m_axis_ready_i(m_axis_ready_i),
    .m_axis_beat_o(m_axis_beat_o),
    .usb_sof_o(usb_sof_o),
    .usb_crc_error_o(usb_crc_error_o)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input int expected, input int actual);
    assert (expected == actual) else report_mismatch(name, expected, actual);
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr_bit();
    end
    return b;
  endfunction

  // Stalled streams must hold their beat
  assert property (@(posedge clock) disable iff (!areset_n)
    tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_beat_o))
  else report_failure("transmit beat changed while the PHY stalled it");

  assert property (@(posedge clock) disable iff (!areset_n)
    m_axis_valid_o && !m_axis_ready_i |=> m_axis_valid_o && $stable(m_axis_beat_o))
  else report_failure("OUT data beat changed while the user stalled it");

  always @(posedge clock) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      report_failure($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  // Monitors for tx, m_axis and the status pulses
  always @(posedge clock) begin
    if (tx_valid_o && tx_ready_i) tx_q.push_back(tx_beat_o);
    if (m_axis_valid_o && m_axis_ready_i) m_q.push_back(m_axis_beat_o);
    if (usb_sof_o) sof_count++;
    if (usb_crc_error_o) crc_count++;
  end

  always @(posedge clock) begin
    #1;
    tx_ready_i     = lfsr_bit();
    m_axis_ready_i = !hold_m && lfsr_bit();
  end

  // User side of the IN endpoint
  always @(posedge clock) begin
    s_fire = s_axis_valid_i && s_axis_ready_o;
    #1;
    if (s_fire) void'(user_q.pop_front());
    s_axis_valid_i = (user_q.size() != 0);
    s_axis_beat_i  = (user_q.size() != 0) ? user_q[0] : '0;
  end

  task automatic send_packet();
    for (int i = 0; i < wire_q.size(); i++) begin
      @(posedge clock);
      #1;
      rx_valid_i = 1'b1;
      rx_beat_i  = '{data: wire_q[i], last: (i == wire_q.size() - 1)};
    end
    @(posedge clock);
    #1;
    rx_valid_i = 1'b0;
    rx_beat_i  = '0;
    wire_q.delete();
    repeat (2) @(posedge clock);
  endtask

  // Also builds SOF with the frame number in the address and endpoint fields
  task automatic send_token(input pid_e pid, input logic [6:0] addr, input logic [3:0] endp);
    logic [4:0] c;
    logic [7:0] b0;
    b0 = {endp[0], addr};
    c  = crc5_step(CRC5_INIT, b0);
    c  = crc5_step(c, {5'b0, endp[3:1]}, 3);
    wire_q.push_back({~pid, pid});
    wire_q.push_back(b0);
    wire_q.push_back({~c, endp[3:1]});
    send_packet();
  endtask

  task automatic send_data(input pid_e pid, input bit corrupt);
    logic [15:0] c;
    c = CRC16_INIT;
    wire_q.push_back({~pid, pid});
    foreach (pay_q[i]) begin
      wire_q.push_back(pay_q[i]);
      c = crc16_step(c, pay_q[i]);
    end
    c = ~c;
    if (corrupt) c = c ^ 16'h0040;
    wire_q.push_back(c[7:0]);
    wire_q.push_back(c[15:8]);
    send_packet();
  endtask

  task automatic send_hsk(input pid_e pid);
    wire_q.push_back({~pid, pid});
    send_packet();
  endtask

  task automatic make_payload(input int n);
    pay_q.delete();
    repeat (n) pay_q.push_back(rand_byte());
  endtask

  task automatic queue_user(input int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      b = rand_byte();
      in_src.push_back(b);
      user_q.push_back('{data: b, last: (i == n - 1)});
    end
  endtask

  task automatic expect_delivery();
    foreach (pay_q[i]) exp_m.push_back('{data: pay_q[i], last: (i == pay_q.size() - 1)});
  endtask

  task automatic wait_tx(input int n);
    while (tx_q.size() < n) @(posedge clock);
  endtask

  task automatic expect_hsk(input string name, input pid_e pid);
    wait_tx(1);
    check_eq(name, int'({~pid, pid, 1'b1}), int'(tx_q[0]));
    repeat (4) @(posedge clock);
    check_eq({name, "_beats"}, 1, tx_q.size());
    tx_q.delete();
  endtask

  task automatic expect_in_data(input string name, input pid_e pid, input int n);
    byte_beat_t  e[$];
    logic [7:0]  b;
    logic [15:0] c;
    c = CRC16_INIT;
    e.push_back('{data: {~pid, pid}, last: 1'b0});
    repeat (n) begin
      b = in_src.pop_front();
      e.push_back('{data: b, last: 1'b0});
      c = crc16_step(c, b);
    end
    c = ~c;
    e.push_back('{data: c[7:0], last: 1'b0});
    e.push_back('{data: c[15:8], last: 1'b1});
    wait_tx(e.size());
    foreach (e[i]) check_eq(name, int'(e[i]), int'(tx_q[i]));
    repeat (4) @(posedge clock);
    check_eq({name, "_beats"}, e.size(), tx_q.size());
    tx_q.delete();
  endtask

  task automatic check_m(input string name);
    while (m_q.size() < exp_m.size()) @(posedge clock);
    repeat (4) @(posedge clock);
    check_eq({name, "_beats"}, exp_m.size(), m_q.size());
    foreach (exp_m[i]) check_eq(name, int'(exp_m[i]), int'(m_q[i]));
    exp_m.delete();
    m_q.delete();
  endtask

  task automatic expect_silence(input string name);
    repeat (20) @(posedge clock);
    check_eq({name, "_tx"}, 0, tx_q.size());
    check_eq({name, "_m_axis"}, 0, m_q.size());
  endtask

  initial begin
    int crc_before;
    int sof_before;
    areset_n       = 1'b0;
    rx_valid_i     = 1'b0;
    rx_beat_i      = '0;
    tx_ready_i     = 1'b0;
    s_axis_valid_i = 1'b0;
    s_axis_beat_i  = '0;
    m_axis_ready_i = 1'b0;
    hold_m         = 1'b0;
    repeat (10) @(posedge clock);
    #1;
    areset_n = 1'b1;
    check_eq("reset_tx_valid", 0, tx_valid_o);
    check_eq("reset_m_axis_valid", 0, m_axis_valid_o);
    check_eq("reset_s_axis_ready", 0, s_axis_ready_o);
    check_eq("reset_sof", 0, usb_sof_o);
    check_eq("reset_crc_error", 0, usb_crc_error_o);
    repeat (4) @(posedge clock);

    // Good OUT with DATA0
    make_payload(6);
    send_token(PID_OUT, DEV_ADDR, OUT_EP);
    send_data(PID_DATA0, 1'b0);
    expect_hsk("out_data0_ack", PID_ACK);
    expect_delivery();
    check_m("out_data0_payload");

    // Corrupted CRC16 followed by the same packet intact
    make_payload(5);
    crc_before = crc_count;
    send_token(PID_OUT, DEV_ADDR, OUT_EP);
    send_data(PID_DATA1, 1'b1);
    expect_silence("out_bad_crc");
    check_eq("out_bad_crc_pulse", crc_before + 1, crc_count);
    send_token(PID_OUT, DEV_ADDR, OUT_EP);
    send_data(PID_DATA1, 1'b0);
    expect_hsk("out_retry_ack", PID_ACK);
    expect_delivery();
    check_m("out_retry_payload");

    // Repeated toggle is acknowledged and dropped
    send_token(PID_OUT, DEV_ADDR, OUT_EP);
    send_data(PID_DATA1, 1'b0);
    expect_hsk("out_repeat_ack", PID_ACK);
    expect_silence("out_repeat_drop");

    // Fill the FIFO until free space is short of a packet
    hold_m = 1'b1;
    for (int i = 0; i < DEPTH / MAX_PKT; i++) begin
      make_payload(MAX_PKT);
      send_token(PID_OUT, DEV_ADDR, OUT_EP);
      send_data((i % 2) ? PID_DATA1 : PID_DATA0, 1'b0);
      expect_hsk("out_fill_ack", PID_ACK);
      expect_delivery();
    end
    make_payload(MAX_PKT);
    send_token(PID_OUT, DEV_ADDR, OUT_EP);
    send_data(PID_DATA0, 1'b0);
    expect_hsk("out_full_nak", PID_NAK);
    hold_m = 1'b0;
    check_m("out_fill_payload");
    send_token(PID_OUT, DEV_ADDR, OUT_EP);
    send_data(PID_DATA0, 1'b0);
    expect_hsk("out_after_nak_ack", PID_ACK);
    expect_delivery();
    check_m("out_after_nak_payload");

    // IN endpoint
    send_token(PID_IN, DEV_ADDR, IN_EP);
    expect_hsk("in_empty_nak", PID_NAK);
    queue_user(5);
    repeat (3) @(posedge clock);
    send_token(PID_IN, DEV_ADDR, IN_EP);
    expect_in_data("in_data0", PID_DATA0, 5);
    send_hsk(PID_ACK);
    queue_user(MAX_PKT + 2);
    repeat (3) @(posedge clock);
    send_token(PID_IN, DEV_ADDR, IN_EP);
    expect_in_data("in_split_first", PID_DATA1, MAX_PKT);
    send_hsk(PID_ACK);
    send_token(PID_IN, DEV_ADDR, IN_EP);
    expect_in_data("in_split_second", PID_DATA0, 2);
    send_hsk(PID_ACK);

    // Tokens that are not ours and an SOF
    // An IN to the endpoint would draw a NAK if the address got through
    send_token(PID_IN, DEV_ADDR + 7'd1, IN_EP);
    expect_silence("other_address");
    send_token(PID_IN, DEV_ADDR, 4'd3);
    expect_silence("other_endpoint");
    sof_before = sof_count;
    send_token(PID_SOF, 7'h2a, 4'h5);
    expect_silence("sof_quiet");
    check_eq("sof_pulse", sof_before + 1, sof_count);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: logic/usb_bulk_core.sv
`timescale 1ns/10ps

module usb_bulk_core #(
  parameter logic [6:0] DEVICE_ADDRESS = 7'd1,
  parameter logic [3:0] OUT_ENDPOINT   = 4'd1,
  parameter logic [3:0] IN_ENDPOINT    = 4'd1,
  parameter int         MAX_PACKET     = 64,
  parameter int         FIFO_DEPTH     = 512
) (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 rx_valid_i,
  input  axis_pkg::byte_beat_t rx_beat_i,
  output logic                 tx_valid_o,
  input  logic                 tx_ready_i,
  output axis_pkg::byte_beat_t tx_beat_o,
  input  logic                 s_axis_valid_i,
  output logic                 s_axis_ready_o,
  input  axis_pkg::byte_beat_t s_axis_beat_i,
  output logic                 m_axis_valid_o,
  input  logic                 m_axis_ready_i,
  output axis_pkg::byte_beat_t m_axis_beat_o,
  output logic                 usb_sof_o,
  output logic                 usb_crc_error_o
);

  import usb_pkg::*;
  import axis_pkg::*;

  logic [1:0]  rst_sync;
  logic        core_rst_n;
  logic        tok_valid;
  token_t      tok;
  logic        data_start;
  pid_e        data_pid;
  logic        data_valid;
  byte_beat_t  data_beat;
  logic        data_end;
  logic        data_ok;
  logic        hsk_valid;
  pid_e        hsk_pid;
  logic        fifo_wr_valid;
  byte_beat_t  fifo_wr_beat;
  logic        fifo_commit;
  logic        fifo_discard;
  logic [15:0] fifo_free;
  logic        hsk_send;
  pid_e        tx_hsk_pid;
  logic        tx_data_start;
  pid_e        tx_data_pid;
  logic        pay_valid;
  logic        pay_ready;
  byte_beat_t  pay_beat;

  // Release of reset is synchronised to the clock, assertion is not
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign core_rst_n = rst_sync[1];

  packet_decoder #(
    .DEVICE_ADDRESS(DEVICE_ADDRESS)
  ) decoder_i (
    .clock(clock),
    .areset_n(core_rst_n),
    .rx_valid_i(rx_valid_i),
    .rx_beat_i(rx_beat_i),
    .tok_valid_o(tok_valid),
    .tok_o(tok),
    .sof_o(usb_sof_o),
    .data_start_o(data_start),
    .data_pid_o(data_pid),
    .data_valid_o(data_valid),
    .data_beat_o(data_beat),
    .data_end_o(data_end),
    .data_ok_o(data_ok),
    .hsk_valid_o(hsk_valid),
    .hsk_pid_o(hsk_pid),
    .crc_err_o(usb_crc_error_o)
  );

  bulk_endpoint_ctrl #(
    .OUT_ENDPOINT(OUT_ENDPOINT),
    .IN_ENDPOINT(IN_ENDPOINT),
    .MAX_PACKET(MAX_PACKET)
  ) ctrl_i (
    .clock(clock),
    .areset_n(core_rst_n),
    .tok_valid_i(tok_valid),
    .tok_i(tok),
    .data_start_i(data_start),
    .data_pid_i(data_pid),
    .data_valid_i(data_valid),
    .data_beat_i(data_beat),
    .data_end_i(data_end),
    .data_ok_i(data_ok),
    .hsk_valid_i(hsk_valid),
    .hsk_pid_i(hsk_pid),
    .fifo_wr_valid_o(fifo_wr_valid),
    .fifo_wr_beat_o(fifo_wr_beat),
    .fifo_commit_o(fifo_commit),
    .fifo_discard_o(fifo_discard),
    .fifo_free_i(fifo_free),
    .hsk_send_o(hsk_send),
    .hsk_pid_o(tx_hsk_pid),
    .tx_data_start_o(tx_data_start),
    .tx_data_pid_o(tx_data_pid),
    .pay_valid_o(pay_valid),
    .pay_ready_i(pay_ready),
    .pay_beat_o(pay_beat),
    .s_axis_valid_i(s_axis_valid_i),
    .s_axis_ready_o(s_axis_ready_o),
    .s_axis_beat_i(s_axis_beat_i)
  );

  packet_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) out_fifo_i (
    .clock(clock),
    .areset_n(core_rst_n),
    .wr_valid_i(fifo_wr_valid),
    .wr_beat_i(fifo_wr_beat),
    .commit_i(fifo_commit),
    .discard_i(fifo_discard),
    .free_o(fifo_free),
    .rd_valid_o(m_axis_valid_o),
    .rd_ready_i(m_axis_ready_i),
    .rd_beat_o(m_axis_beat_o)
  );

  packet_encoder encoder_i (
    .clock(clock),
    .areset_n(core_rst_n),
    .hsk_send_i(hsk_send),
    .hsk_pid_i(tx_hsk_pid),
    .data_start_i(tx_data_start),
    .data_pid_i(tx_data_pid),
    .pay_valid_i(pay_valid),
    .pay_ready_o(pay_ready),
    .pay_beat_i(pay_beat),
    .tx_valid_o(tx_valid_o),
    .tx_ready_i(tx_ready_i),
    .tx_beat_o(tx_beat_o)
  );

endmodule

// File: logic/bulk_endpoint_ctrl.sv
`timescale 1ns/10ps

module bulk_endpoint_ctrl #(
  parameter logic [3:0] OUT_ENDPOINT = 4'd1,
  parameter logic [3:0] IN_ENDPOINT  = 4'd1,
  parameter int         MAX_PACKET   = 64
) (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 tok_valid_i,
  input  usb_pkg::token_t      tok_i,
  input  logic                 data_start_i,
  input  usb_pkg::pid_e        data_pid_i,
  input  logic                 data_valid_i,
  input  axis_pkg::byte_beat_t data_beat_i,
  input  logic                 data_end_i,
  input  logic                 data_ok_i,
  input  logic                 hsk_valid_i,
  input  usb_pkg::pid_e        hsk_pid_i,
  output logic                 fifo_wr_valid_o,
  output axis_pkg::byte_beat_t fifo_wr_beat_o,
  output logic                 fifo_commit_o,
  output logic                 fifo_discard_o,
  input  logic [15:0]          fifo_free_i,
  output logic                 hsk_send_o,
  output usb_pkg::pid_e        hsk_pid_o,
  output logic                 tx_data_start_o,
  output usb_pkg::pid_e        tx_data_pid_o,
  output logic                 pay_valid_o,
  input  logic                 pay_ready_i,
  output axis_pkg::byte_beat_t pay_beat_o,
  input  logic                 s_axis_valid_i,
  output logic                 s_axis_ready_o,
  input  axis_pkg::byte_beat_t s_axis_beat_i
);

  import usb_pkg::*;
  import axis_pkg::*;

  localparam int CW = $clog2(MAX_PACKET + 1);

  typedef enum logic [1:0] {
    C_IDLE,
    C_OUT_DATA,
    C_IN_DATA,
    C_IN_WAIT
  } state_e;

  state_e        state;
  pid_e          out_pid_q;
  logic          out_toggle;
  logic          in_toggle;
  logic          accept_q;
  logic [CW-1:0] pay_cnt;
  logic          tok_out;
  logic          tok_in;
  logic          out_good;
  logic          pay_fire;

  assign tok_out = tok_valid_i && (tok_i.pid == PID_OUT) && (tok_i.endp == OUT_ENDPOINT);
  assign tok_in  = tok_valid_i && (tok_i.pid == PID_IN) && (tok_i.endp == IN_ENDPOINT);

  // Good, room was there, and the toggle is the one expected
  assign out_good = data_ok_i && accept_q &&
                    (out_pid_q == (out_toggle ? PID_DATA1 : PID_DATA0));

  assign fifo_wr_valid_o = (state == C_OUT_DATA) && accept_q && data_valid_i;
  assign fifo_wr_beat_o  = data_beat_i;
  assign fifo_commit_o   = (state == C_OUT_DATA) && data_end_i && out_good;
  assign fifo_discard_o  = (state == C_OUT_DATA) && data_end_i && !out_good;

  // IN payload is cut at MAX_PACKET bytes
  assign pay_valid_o    = (state == C_IN_DATA) && s_axis_valid_i;
  assign s_axis_ready_o = (state == C_IN_DATA) && pay_ready_i;
  assign pay_beat_o     = '{data: s_axis_beat_i.data,
                            last: s_axis_beat_i.last || (pay_cnt == CW'(MAX_PACKET - 1))};
  assign pay_fire       = pay_valid_o && pay_ready_i;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state           <= C_IDLE;
      out_pid_q       <= PID_DATA0;
      out_toggle      <= 1'b0;
      in_toggle       <= 1'b0;
      accept_q        <= 1'b0;
      pay_cnt         <= '0;
      hsk_send_o      <= 1'b0;
      hsk_pid_o       <= PID_ACK;
      tx_data_start_o <= 1'b0;
      tx_data_pid_o   <= PID_DATA0;
    end else begin
      hsk_send_o      <= 1'b0;
      tx_data_start_o <= 1'b0;
      case (state)
        C_OUT_DATA: begin
          if (data_start_i) begin
            out_pid_q <= data_pid_i;
            accept_q  <= (fifo_free_i >= 16'(MAX_PACKET));
          end
          if (data_end_i) begin
            state <= C_IDLE;
            // A corrupted packet gets no answer
            if (data_ok_i) begin
              hsk_send_o <= 1'b1;
              hsk_pid_o  <= accept_q ? PID_ACK : PID_NAK;
            end
            if (fifo_commit_o) out_toggle <= !out_toggle;
          end
        end
        C_IN_DATA: begin
          if (pay_fire) pay_cnt <= pay_cnt + CW'(1);
          if (pay_fire && pay_beat_o.last) state <= C_IN_WAIT;
        end
        C_IN_WAIT: begin
          if (hsk_valid_i || data_start_i) state <= C_IDLE;
          if (hsk_valid_i && (hsk_pid_i == PID_ACK)) in_toggle <= !in_toggle;
        end
        default: ;
      endcase
      // A new token ends any open transaction that is not sending
      if ((state != C_IN_DATA) && tok_valid_i) begin
        state <= C_IDLE;
        if (tok_out) begin
          state <= C_OUT_DATA;
        end else if (tok_in && s_axis_valid_i) begin
          state           <= C_IN_DATA;
          pay_cnt         <= '0;
          tx_data_start_o <= 1'b1;
          tx_data_pid_o   <= in_toggle ? PID_DATA1 : PID_DATA0;
        end else if (tok_in) begin
          hsk_send_o <= 1'b1;
          hsk_pid_o  <= PID_NAK;
        end
      end
    end
  end

endmodule

// File: logic/packet_fifo.sv
`timescale 1ns/10ps

module packet_fifo #(
  parameter int FIFO_DEPTH = 512
) (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 wr_valid_i,
  input  axis_pkg::byte_beat_t wr_beat_i,
  input  logic                 commit_i,
  input  logic                 discard_i,
  output logic [15:0]          free_o,
  output logic                 rd_valid_o,
  input  logic                 rd_ready_i,
  output axis_pkg::byte_beat_t rd_beat_o
);

  import axis_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int PW = AW + 1;

  byte_beat_t    mem [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] cmt_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW-1:0] wr_nxt;
  logic [PW-1:0] used;
  logic          wr_en;

  // Space counts tentative bytes, the reader sees committed ones only
  assign used       = wr_ptr - rd_ptr;
  assign wr_en      = wr_valid_i && (used != PW'(FIFO_DEPTH));
  assign wr_nxt     = wr_ptr + PW'(wr_en);
  assign free_o     = 16'(FIFO_DEPTH) - 16'(used);
  assign rd_valid_o = (rd_ptr != cmt_ptr);
  assign rd_beat_o  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clock) begin
    if (wr_en) mem[wr_ptr[AW-1:0]] <= wr_beat_i;
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr  <= '0;
      cmt_ptr <= '0;
      rd_ptr  <= '0;
    end else begin
      wr_ptr <= discard_i ? cmt_ptr : wr_nxt;
      if (commit_i) cmt_ptr <= wr_nxt;
      if (rd_valid_o && rd_ready_i) rd_ptr <= rd_ptr + PW'(1);
    end
  end

endmodule

// File: logic/packet_encoder.sv
`timescale 1ns/10ps

module packet_encoder (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 hsk_send_i,
  input  usb_pkg::pid_e        hsk_pid_i,
  input  logic                 data_start_i,
  input  usb_pkg::pid_e        data_pid_i,
  input  logic                 pay_valid_i,
  output logic                 pay_ready_o,
  input  axis_pkg::byte_beat_t pay_beat_i,
  output logic                 tx_valid_o,
  input  logic                 tx_ready_i,
  output axis_pkg::byte_beat_t tx_beat_o
);

  import usb_pkg::*;
  import axis_pkg::*;

  typedef enum logic [2:0] {
    E_IDLE,
    E_HSK,
    E_PID,
    E_PAY,
    E_CRC_LO,
    E_CRC_HI
  } state_e;

  state_e      state;
  pid_e        pid_q;
  logic [15:0] crc_q;
  logic [15:0] crc_tx;
  logic        tx_fire;

  // Sent inverted, low byte first
  assign crc_tx      = ~crc_q;
  assign tx_fire     = tx_valid_o && tx_ready_i;
  assign pay_ready_o = (state == E_PAY) && tx_ready_i;

  always_comb begin
    tx_valid_o = (state != E_IDLE);
    tx_beat_o  = '{data: {~pid_q, pid_q}, last: 1'b0};
    case (state)
      E_HSK: tx_beat_o.last = 1'b1;
      E_PAY: begin
        tx_valid_o     = pay_valid_i;
        tx_beat_o.data = pay_beat_i.data;
      end
      E_CRC_LO: tx_beat_o.data = crc_tx[7:0];
      E_CRC_HI: tx_beat_o = '{data: crc_tx[15:8], last: 1'b1};
      default: ;
    endcase
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state <= E_IDLE;
    end else begin
      case (state)
        E_IDLE: begin
          if (hsk_send_i) begin
            state <= E_HSK;
          end else if (data_start_i) begin
            state <= E_PID;
          end
        end
        E_HSK: if (tx_fire) state <= E_IDLE;
        E_PID: if (tx_fire) state <= E_PAY;
        E_PAY: if (tx_fire && pay_beat_i.last) state <= E_CRC_LO;
        E_CRC_LO: if (tx_fire) state <= E_CRC_HI;
        E_CRC_HI: if (tx_fire) state <= E_IDLE;
        default: state <= E_IDLE;
      endcase
    end
  end

  // PID is sampled while idle and frozen for the rest of the packet
  always_ff @(posedge clock) begin
    if (state == E_IDLE) begin
      pid_q <= hsk_send_i ? hsk_pid_i : data_pid_i;
      crc_q <= CRC16_INIT;
    end else if ((state == E_PAY) && tx_fire) begin
      crc_q <= crc16_step(crc_q, pay_beat_i.data);
    end
  end

endmodule

// File: logic/packet_decoder.sv
`timescale 1ns/10ps

module packet_decoder #(
  parameter logic [6:0] DEVICE_ADDRESS = 7'd1
) (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 rx_valid_i,
  input  axis_pkg::byte_beat_t rx_beat_i,
  output logic                 tok_valid_o,
  output usb_pkg::token_t      tok_o,
  output logic                 sof_o,
  output logic                 data_start_o,
  output usb_pkg::pid_e        data_pid_o,
  output logic                 data_valid_o,
  output axis_pkg::byte_beat_t data_beat_o,
  output logic                 data_end_o,
  output logic                 data_ok_o,
  output logic                 hsk_valid_o,
  output usb_pkg::pid_e        hsk_pid_o,
  output logic                 crc_err_o
);

  import usb_pkg::*;
  import axis_pkg::*;

  typedef enum logic [1:0] {
    S_PID,
    S_TOKEN,
    S_DATA,
    S_SKIP
  } state_e;

  state_e      state;
  pid_e        rx_pid;
  pid_e        pid_q;
  logic        pid_ok;
  logic        tok_second;
  logic [7:0]  tok_byte0;
  logic [4:0]  crc5_q;
  logic [4:0]  crc5_nxt;
  logic [15:0] crc16_q;
  logic [15:0] crc16_nxt;
  logic [15:0] hold_q;
  logic [1:0]  held;

  assign rx_pid     = pid_e'(rx_beat_i.data[3:0]);
  assign pid_ok     = (rx_beat_i.data[7:4] == ~rx_beat_i.data[3:0]);
  assign crc5_nxt   = crc5_step(crc5_q, rx_beat_i.data);
  assign crc16_nxt  = crc16_step(crc16_q, rx_beat_i.data);
  assign data_pid_o = pid_q;
  assign hsk_pid_o  = pid_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state        <= S_PID;
      tok_second   <= 1'b0;
      held         <= '0;
      tok_valid_o  <= 1'b0;
      sof_o        <= 1'b0;
      data_start_o <= 1'b0;
      data_valid_o <= 1'b0;
      data_end_o   <= 1'b0;
      data_ok_o    <= 1'b0;
      hsk_valid_o  <= 1'b0;
      crc_err_o    <= 1'b0;
    end else begin
      tok_valid_o  <= 1'b0;
      sof_o        <= 1'b0;
      data_start_o <= 1'b0;
      data_valid_o <= 1'b0;
      data_end_o   <= 1'b0;
      hsk_valid_o  <= 1'b0;
      crc_err_o    <= 1'b0;
      if (rx_valid_i) begin
        case (state)
          S_PID: begin
            tok_second <= 1'b0;
            held       <= '0;
            state      <= rx_beat_i.last ? S_PID : S_SKIP;
            if (pid_ok) begin
              case (rx_pid)
                PID_OUT, PID_IN, PID_SETUP, PID_SOF: begin
                  if (!rx_beat_i.last) state <= S_TOKEN;
                end
                PID_DATA0, PID_DATA1: begin
                  data_start_o <= !rx_beat_i.last;
                  if (!rx_beat_i.last) state <= S_DATA;
                end
                PID_ACK, PID_NAK, PID_STALL: hsk_valid_o <= rx_beat_i.last;
                default: ;
              endcase
            end
          end
          S_TOKEN: begin
            tok_second <= 1'b1;
            if (!tok_second) begin
              // Token cut short after one byte
              if (rx_beat_i.last) state <= S_PID;
            end else if (!rx_beat_i.last) begin
              state <= S_SKIP;
            end else begin
              state <= S_PID;
              if (crc5_nxt != CRC5_RESIDUAL) begin
                crc_err_o <= 1'b1;
              end else if (pid_q == PID_SOF) begin
                sof_o <= 1'b1;
              end else if (tok_byte0[6:0] == DEVICE_ADDRESS) begin
                tok_valid_o <= 1'b1;
              end
            end
          end
          S_DATA: begin
            // Two bytes stay held back so the CRC never leaves
            held         <= (held == 2'd2) ? held : held + 2'd1;
            data_valid_o <= (held == 2'd2);
            if (rx_beat_i.last) begin
              state      <= S_PID;
              data_end_o <= 1'b1;
              data_ok_o  <= (crc16_nxt == CRC16_RESIDUAL) && (held != 2'd0);
              crc_err_o  <= (crc16_nxt != CRC16_RESIDUAL);
            end
          end
          default: begin
            if (rx_beat_i.last) state <= S_PID;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_valid_i) begin
      case (state)
        S_PID: begin
          pid_q   <= rx_pid;
          crc5_q  <= CRC5_INIT;
          crc16_q <= CRC16_INIT;
        end
        S_TOKEN: begin
          crc5_q    <= crc5_nxt;
          tok_byte0 <= rx_beat_i.data;
          tok_o     <= '{pid: pid_q, addr: tok_byte0[6:0],
                         endp: {rx_beat_i.data[2:0], tok_byte0[7]}};
        end
        S_DATA: begin
          crc16_q     <= crc16_nxt;
          hold_q      <= {hold_q[7:0], rx_beat_i.data};
          data_beat_o <= '{data: hold_q[15:8], last: rx_beat_i.last};
        end
        default: ;
      endcase
    end
  end

endmodule

// File: logic/axis_pkg.sv
package axis_pkg;

  // One byte of a stream, valid and ready travel beside it
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

endpackage

// File: logic/usb_pkg.sv
package usb_pkg;

  // Low nibble of the PID byte, the high nibble carries its complement
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } pid_e;

  typedef struct packed {
    pid_e       pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } token_t;

  // CRC registers are bit reversed, bit 0 is the first bit on the wire
  localparam logic [4:0]  CRC5_INIT      = 5'h1f;
  localparam logic [4:0]  CRC5_RESIDUAL  = 5'h06;
  localparam logic [15:0] CRC16_INIT     = 16'hffff;
  localparam logic [15:0] CRC16_RESIDUAL = 16'hb001;

  // Folds the low nbits of a byte, LSB first; a token builder needs nbits of 3
  function automatic logic [4:0] crc5_step(input logic [4:0] crc, input logic [7:0] data,
                                           input int unsigned nbits = 8);
    logic [4:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (i < nbits) begin
        c = (c[0] ^ data[i]) ? ((c >> 1) ^ 5'h14) : (c >> 1);
      end
    end
    return c;
  endfunction

  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      c = (c[0] ^ data[i]) ? ((c >> 1) ^ 16'ha001) : (c >> 1);
    end
    return c;
  endfunction

endpackage
